// File: accel_control.f
hw/accel_pkg.sv
hw/layer_dispatch.sv
hw/conv_sequencer.sv
hw/add_sequencer.sv
hw/single_op_sequencer.sv
hw/accel_control.sv
bench/accel_checker.sv
bench/accel_control_props.sv
bench/tb_accel_control.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_accel_control \
		-f accel_control.f -o sim_accel
	./obj_dir/sim_accel | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_accel_control.sv
// ######################################
// accelerator control testbench
// ######################################
`timescale 1ns/1ps

module tb_accel_control;

	localparam int NUM_TESTS = 12;

	typedef struct packed {
		logic [1:0]            pre;       // 1 task_start, 2 task_finish first
		logic [2:0]            order;
		accel_pkg::patch_cnt_t n;
		accel_pkg::patch_cnt_t m;
		logic [3:0]            max_delay;
		logic                  accept;    // command should run
	} entry_t;

	// pre, order, in, out, max delay, runs
	entry_t tests [NUM_TESTS] = '{
		'{2'd0, 3'd1, 8'd2, 8'd2, 4'd2, 1'b0}, // no task open yet
		'{2'd1, 3'd1, 8'd3, 8'd2, 4'd3, 1'b1},
		'{2'd0, 3'd2, 8'd1, 8'd1, 4'd2, 1'b1},
		'{2'd0, 3'd3, 8'd4, 8'd1, 4'd1, 1'b1},
		'{2'd0, 3'd4, 8'd3, 8'd1, 4'd4, 1'b1},
		'{2'd0, 3'd6, 8'd2, 8'd1, 4'd1, 1'b0}, // unknown order
		'{2'd0, 3'd1, 8'd1, 8'd3, 4'd8, 1'b1},
		'{2'd0, 3'd1, 8'd4, 8'd1, 4'd15, 1'b1},
		'{2'd2, 3'd2, 8'd1, 8'd1, 4'd1, 1'b0}, // task closed
		'{2'd0, 3'd3, 8'd2, 8'd1, 4'd2, 1'b0},
		'{2'd1, 3'd4, 8'd2, 8'd1, 4'd15, 1'b1},
		'{2'd0, 3'd1, 8'd2, 8'd2, 4'd1, 1'b1}
	};

	logic                    system_clk      = 1'b0;
	logic                    rst_n           = 1'b0;
	logic                    task_start      = 1'b0;
	logic                    task_finish     = 1'b0;
	logic                    calculate_start = 1'b0;
	accel_pkg::accel_cmd_t   cmd             = '0;
	logic                    weights_ready   = 1'b0;
	logic                    compute_finish  = 1'b0;
	logic                    return_finish   = 1'b0;
	accel_pkg::ctrl_strobe_t ctrl;
	accel_pkg::path_sel_t    path_sel;
	logic                    buffer_done;
	logic                    idle;

	int          test_id     = 0;
	logic        cur_accept  = 1'b0;
	logic [3:0]  cur_delay   = 4'd1;
	logic        test_active = 1'b0;
	logic [31:0] rng         = 32'he62b_0074;
	int          w_wait      = 0;
	int          c_wait      = 0;
	int          r_wait      = 0;
	logic        ret_armed   = 1'b0;
	int          cycle_cnt   = 0;
	int          cycle_limit = 0;
	int          idx;
	int          tests_done;
	int          tests_failed;
	int          errors;

	accel_control uut (
		.system_clk      (system_clk),
		.rst_n           (rst_n),
		.task_start      (task_start),
		.task_finish     (task_finish),
		.calculate_start (calculate_start),
		.cmd             (cmd),
		.weights_ready   (weights_ready),
		.compute_finish  (compute_finish),
		.return_finish   (return_finish),
		.ctrl            (ctrl),
		.path_sel        (path_sel),
		.buffer_done     (buffer_done),
		.idle            (idle)
	);

	accel_checker u_checker (
		.system_clk    (system_clk),
		.rst_n         (rst_n),
		.ctrl          (ctrl),
		.path_sel      (path_sel),
		.buffer_done   (buffer_done),
		.idle          (idle),
		.return_finish (return_finish),
		.cmd           (cmd),
		.accept        (cur_accept),
		.test_active   (test_active),
		.test_id       (test_id),
		.tests_done    (tests_done),
		.tests_failed  (tests_failed),
		.errors        (errors)
	);

	always #10 system_clk = ~system_clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function int draw_delay();
		rng = xorshift32(rng);
		return 1 + int'(rng % 32'(cur_delay));
	endfunction

	function automatic int run_limit();
		int sum;
		int i;
		sum = 0;
		for (i = 0; i < NUM_TESTS; i++)
			sum += int'(tests[i].n) * int'(tests[i].m) * (3 + 3 * int'(tests[i].max_delay));
		return 4 * sum + 200;
	endfunction

	// datapath model answering the control strobes
	always @(posedge system_clk) begin
		weights_ready  <= 1'b0;
		compute_finish <= 1'b0;
		return_finish  <= 1'b0;
		if (r_wait == 1) begin
			return_finish <= 1'b1;
			ret_armed = 1'b0;
		end
		if (r_wait > 0)
			r_wait--;
		if (w_wait == 1)
			weights_ready <= 1'b1;
		if (w_wait > 0)
			w_wait--;
		if (c_wait == 1) begin
			compute_finish <= 1'b1;
			if (ret_armed)
				r_wait = draw_delay() + 2; // write-back after the compute
		end
		if (c_wait > 0)
			c_wait--;
		if (ctrl.change_weights != 2'd0)
			w_wait = draw_delay();
		if (ctrl.compute_begin)
			c_wait = draw_delay();
		if (ctrl.return_req)
			ret_armed = 1'b1;
	end

	always @(posedge system_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		cycle_limit = run_limit();
		repeat (8) @(posedge system_clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge system_clk);
		for (idx = 0; idx < NUM_TESTS; idx++) begin
			@(posedge system_clk);
			test_id     <= idx;
			cur_accept  <= tests[idx].accept;
			cur_delay   <= tests[idx].max_delay;
			test_active <= 1'b1;
			task_start  <= (tests[idx].pre == 2'd1);
			task_finish <= (tests[idx].pre == 2'd2);
			@(posedge system_clk);
			task_start      <= 1'b0;
			task_finish     <= 1'b0;
			calculate_start <= 1'b1;
			cmd <= accel_pkg::accel_cmd_t'({tests[idx].order, tests[idx].n, tests[idx].m});
			@(posedge system_clk);
			calculate_start <= 1'b0;
			if (tests[idx].accept) begin
				while (idle)
					@(posedge system_clk);
				while (!idle)
					@(posedge system_clk);
			end else begin
				repeat (10) @(posedge system_clk); // nothing may start
			end
			test_active <= 1'b0;
			@(posedge system_clk);
		end
		repeat (3) @(posedge system_clk);
		$display("tests: %0d  failed: %0d  errors: %0d", tests_done, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: bench/accel_control_props.sv
// ######################################
// control assertions
// ######################################
`timescale 1ns/1ps

module accel_control_props (
	input logic                    system_clk,
	input logic                    rst_n,
	input logic                    conv_go,
	input logic                    add_go,
	input logic                    single_go,
	input accel_pkg::accel_cmd_t   cmd_latched,
	input accel_pkg::ctrl_strobe_t ctrl,
	input accel_pkg::path_sel_t    path_sel
);

	one_go: assert property (@(posedge system_clk) disable iff (!rst_n)
		$onehot0({conv_go, add_go, single_go}))
		else $error("more than one sequencer started in a cycle");

	one_path: assert property (@(posedge system_clk) disable iff (!rst_n)
		$onehot0(path_sel))
		else $error("more than one path selected");

	// strobes last a single cycle
	lf_pulse: assert property (@(posedge system_clk) disable iff (!rst_n)
		ctrl.load_feature |=> !ctrl.load_feature)
		else $error("load_feature longer than one cycle");
	cb_pulse: assert property (@(posedge system_clk) disable iff (!rst_n)
		ctrl.compute_begin |=> !ctrl.compute_begin)
		else $error("compute_begin longer than one cycle");
	rr_pulse: assert property (@(posedge system_clk) disable iff (!rst_n)
		ctrl.return_req |=> !ctrl.return_req)
		else $error("return_req longer than one cycle");
	rf_pulse: assert property (@(posedge system_clk) disable iff (!rst_n)
		ctrl.refresh_return |=> !ctrl.refresh_return)
		else $error("refresh_return longer than one cycle");
	fr_pulse: assert property (@(posedge system_clk) disable iff (!rst_n)
		ctrl.free_read_addr |=> !ctrl.free_read_addr)
		else $error("free_read_addr longer than one cycle");
	cw_pulse: assert property (@(posedge system_clk) disable iff (!rst_n)
		(ctrl.change_weights != 2'd0) |=> (ctrl.change_weights == 2'd0))
		else $error("change_weights longer than one cycle");

	in_nonzero: assert property (@(posedge system_clk) disable iff (!rst_n)
		(conv_go || single_go) |-> (cmd_latched.in_patches != 8'd0))
		else $error("layer started with zero input patches");
	out_nonzero: assert property (@(posedge system_clk) disable iff (!rst_n)
		conv_go |-> (cmd_latched.out_patches != 8'd0))
		else $error("convolution started with zero output patches");

endmodule

bind accel_control accel_control_props u_props (
	.system_clk  (system_clk),
	.rst_n       (rst_n),
	.conv_go     (conv_go),
	.add_go      (add_go),
	.single_go   (single_go),
	.cmd_latched (cmd_latched),
	.ctrl        (ctrl),
	.path_sel    (path_sel)
);

// File: bench/accel_checker.sv
// ######################################
// control strobe checker
// ######################################
`timescale 1ns/1ps

module accel_checker (
	input  logic                    system_clk,
	input  logic                    rst_n,
	input  accel_pkg::ctrl_strobe_t ctrl,
	input  accel_pkg::path_sel_t    path_sel,
	input  logic                    buffer_done,
	input  logic                    idle,
	input  logic                    return_finish,
	input  accel_pkg::accel_cmd_t   cmd,
	input  logic                    accept,
	input  logic                    test_active,
	input  int                      test_id,
	output int                      tests_done,
	output int                      tests_failed,
	output int                      errors
);

	string cnt_name [7] = '{"load_feature", "compute_begin", "return_req",
		"refresh_return", "free_read_addr", "change_weights 3", "change_weights 1"};

	int   cnt [7];
	int   test_err;
	int   outstanding;
	int   expect_val;
	int   k;
	logic active_q      = 1'b0;
	logic reset_checked = 1'b0;
	logic any_strobe;

	// expected strobe counts per layer
	function automatic int expected_count(input accel_pkg::accel_cmd_t c, input logic acc,
		input int sel);
		int n;
		int m;
		n = int'(c.in_patches);
		m = int'(c.out_patches);
		if (!acc)
			return 0;
		case (c.order)
			accel_pkg::OP_CONV: begin
				case (sel)
					0, 2, 5: return m;
					1:       return n * m;
					3, 4:    return 1;
					default: return m * (n - 1);
				endcase
			end
			accel_pkg::OP_ADD: return (sel < 5) ? 1 : 0;
			default: begin
				case (sel)
					0, 1, 2: return n;
					3, 4:    return 1;
					default: return 0;
				endcase
			end
		endcase
	endfunction

	function automatic accel_pkg::path_sel_t expected_path(input accel_pkg::op_e o);
		accel_pkg::path_sel_t p;
		p          = '0;
		p.conv     = (o == accel_pkg::OP_CONV);
		p.add      = (o == accel_pkg::OP_ADD);
		p.pool     = (o == accel_pkg::OP_POOL);
		p.upsample = (o == accel_pkg::OP_UPSAMPLE);
		return p;
	endfunction

	task flag_error(input string msg);
		errors++;
		test_err++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	always @(posedge system_clk) begin
		any_strobe = ctrl.load_feature | ctrl.compute_begin | ctrl.return_req |
			ctrl.refresh_return | ctrl.free_read_addr | (ctrl.change_weights != 2'd0);
		if (!rst_n) begin
			outstanding = 0;
		end else begin
			if (!reset_checked) begin
				reset_checked = 1'b1;
				test_err      = 0;
				tests_done++;
				if (ctrl != '0 || path_sel != '0 || buffer_done || !idle)
					flag_error("outputs not at their reset values");
				if (test_err == 0) begin
					$display("test reset: ok");
				end else begin
					tests_failed++;
					$display("test reset: FAILED");
				end
			end
			if (test_active && !active_q) begin
				for (k = 0; k < 7; k++)
					cnt[k] = 0;
				test_err = 0;
			end
			if (test_active) begin
				if (ctrl.load_feature)   cnt[0]++;
				if (ctrl.compute_begin)  cnt[1]++;
				if (ctrl.return_req)     cnt[2]++;
				if (ctrl.refresh_return) cnt[3]++;
				if (ctrl.free_read_addr) cnt[4]++;
				if (ctrl.change_weights == 2'd3) cnt[5]++;
				if (ctrl.change_weights == 2'd1) cnt[6]++;
				if (ctrl.change_weights == 2'd2)
					flag_error($sformatf("test %0d undefined change_weights code 2", test_id));
				if (!accept && !idle)
					flag_error($sformatf("test %0d ignored command started a layer", test_id));
			end else if (any_strobe) begin
				flag_error("strobe outside any test");
			end
			// path selection follows the running layer
			if (idle && path_sel != '0)
				flag_error($sformatf("path_sel %b while idle", path_sel));
			if (!idle && path_sel != expected_path(cmd.order))
				flag_error($sformatf("path_sel %b for order %0d", path_sel, cmd.order));
			if (ctrl.return_req && cmd.order == accel_pkg::OP_CONV && !ctrl.direct_out)
				flag_error("direct_out low at a convolution return_req");
			if (return_finish && !buffer_done)
				flag_error("buffer_done low when return_finish arrived");
			if (buffer_done && outstanding == 0)
				flag_error("buffer_done high with no return pending");
			if (ctrl.return_req)
				outstanding++;
			if (return_finish && outstanding > 0)
				outstanding--;
			if (!test_active && active_q) begin
				for (k = 0; k < 7; k++) begin
					expect_val = expected_count(cmd, accept, k);
					if (cnt[k] != expect_val)
						flag_error($sformatf("test %0d %s count %0d, expected %0d",
							test_id, cnt_name[k], cnt[k], expect_val));
				end
				tests_done++;
				if (test_err == 0) begin
					$display("test %0d order %0d: ok", test_id, cmd.order);
				end else begin
					tests_failed++;
					$display("test %0d order %0d: FAILED, %0d errors", test_id, cmd.order,
						test_err);
				end
			end
		end
		active_q = test_active;
	end

endmodule

// File: hw/accel_control.sv
// ######################################
// accelerator control top
// ######################################
`timescale 1ns/1ps

module accel_control (
	input  logic                    system_clk,
	input  logic                    rst_n,
	input  logic                    task_start,
	input  logic                    task_finish,
	input  logic                    calculate_start,
	input  accel_pkg::accel_cmd_t   cmd,
	input  logic                    weights_ready,
	input  logic                    compute_finish,
	input  logic                    return_finish,
	output accel_pkg::ctrl_strobe_t ctrl,
	output accel_pkg::path_sel_t    path_sel,
	output logic                    buffer_done,
	output logic                    idle
);

	logic                    conv_go, add_go, single_go;
	logic                    conv_done, add_done, single_done;
	logic                    conv_wait, add_wait, single_wait;
	accel_pkg::accel_cmd_t   cmd_latched;
	accel_pkg::ctrl_strobe_t conv_strobes, add_strobes, single_strobes;

	layer_dispatch u_dispatch (
		.system_clk      (system_clk),
		.rst_n           (rst_n),
		.task_start      (task_start),
		.task_finish     (task_finish),
		.calculate_start (calculate_start),
		.cmd             (cmd),
		.conv_done       (conv_done),
		.add_done        (add_done),
		.single_done     (single_done),
		.conv_go         (conv_go),
		.add_go          (add_go),
		.single_go       (single_go),
		.cmd_latched     (cmd_latched),
		.path_sel        (path_sel),
		.idle            (idle)
	);

	conv_sequencer u_conv (
		.system_clk     (system_clk),
		.rst_n          (rst_n),
		.go             (conv_go),
		.in_patches     (cmd_latched.in_patches),
		.out_patches    (cmd_latched.out_patches),
		.weights_ready  (weights_ready),
		.compute_finish (compute_finish),
		.return_finish  (return_finish),
		.strobes        (conv_strobes),
		.wait_return    (conv_wait),
		.done           (conv_done)
	);

	add_sequencer u_add (
		.system_clk     (system_clk),
		.rst_n          (rst_n),
		.go             (add_go),
		.compute_finish (compute_finish),
		.return_finish  (return_finish),
		.strobes        (add_strobes),
		.wait_return    (add_wait),
		.done           (add_done)
	);

	single_op_sequencer u_single (
		.system_clk     (system_clk),
		.rst_n          (rst_n),
		.go             (single_go),
		.in_patches     (cmd_latched.in_patches),
		.compute_finish (compute_finish),
		.return_finish  (return_finish),
		.strobes        (single_strobes),
		.wait_return    (single_wait),
		.done           (single_done)
	);

	// only one sequencer busy at a time
	assign ctrl        = accel_pkg::ctrl_strobe_t'(conv_strobes | add_strobes | single_strobes);
	assign buffer_done = conv_wait | add_wait | single_wait;

endmodule

// File: hw/single_op_sequencer.sv
// ######################################
// pool / upsample sequencer
// ######################################
`timescale 1ns/1ps

module single_op_sequencer (
	input  logic                    system_clk,
	input  logic                    rst_n,
	input  logic                    go,
	input  accel_pkg::patch_cnt_t   in_patches,
	input  logic                    compute_finish,
	input  logic                    return_finish,
	output accel_pkg::ctrl_strobe_t strobes,
	output logic                    wait_return,
	output logic                    done
);

	accel_pkg::single_state_e state;
	accel_pkg::patch_cnt_t    patch_cnt;
	logic                     load_q;
	logic                     refresh_q;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= accel_pkg::SINGLE_IDLE;
			patch_cnt <= '0;
			load_q    <= 1'b0;
			refresh_q <= 1'b0;
		end else begin
			load_q    <= (state == accel_pkg::SINGLE_LOAD);
			refresh_q <= (state == accel_pkg::SINGLE_LOAD) && (patch_cnt == '0); // first patch
			case (state)
				accel_pkg::SINGLE_IDLE: if (go) state <= accel_pkg::SINGLE_LOAD;
				accel_pkg::SINGLE_LOAD: state <= accel_pkg::SINGLE_WAIT_COMPUTE;
				accel_pkg::SINGLE_WAIT_COMPUTE: begin
					if (compute_finish)
						state <= accel_pkg::SINGLE_WAIT_RETURN;
				end
				accel_pkg::SINGLE_WAIT_RETURN: begin
					if (return_finish) begin
						patch_cnt <= patch_cnt + 8'd1;
						state     <= accel_pkg::SINGLE_CHECK;
					end
				end
				accel_pkg::SINGLE_CHECK: begin
					if (patch_cnt == in_patches)
						state <= accel_pkg::SINGLE_DONE;
					else
						state <= accel_pkg::SINGLE_LOAD;
				end
				accel_pkg::SINGLE_DONE: begin
					patch_cnt <= '0;
					state     <= accel_pkg::SINGLE_IDLE;
				end
				default: state <= accel_pkg::SINGLE_IDLE;
			endcase
		end
	end

	always_comb begin
		strobes                = '0;
		strobes.load_feature   = load_q;
		strobes.compute_begin  = load_q;
		strobes.return_req     = load_q;
		strobes.refresh_return = refresh_q;
		strobes.free_read_addr = (state == accel_pkg::SINGLE_DONE);
	end

	assign wait_return = (state == accel_pkg::SINGLE_WAIT_RETURN);
	assign done        = (state == accel_pkg::SINGLE_DONE);

endmodule

// File: hw/add_sequencer.sv
// ######################################
// element-wise add sequencer
// ######################################
`timescale 1ns/1ps

module add_sequencer (
	input  logic                    system_clk,
	input  logic                    rst_n,
	input  logic                    go,
	input  logic                    compute_finish,
	input  logic                    return_finish,
	output accel_pkg::ctrl_strobe_t strobes,
	output logic                    wait_return,
	output logic                    done
);

	accel_pkg::add_state_e state;
	logic                  launch_q;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= accel_pkg::ADD_IDLE;
			launch_q <= 1'b0;
		end else begin
			launch_q <= (state == accel_pkg::ADD_IDLE) && go;
			case (state)
				accel_pkg::ADD_IDLE: if (go) state <= accel_pkg::ADD_WAIT_COMPUTE;
				accel_pkg::ADD_WAIT_COMPUTE: if (compute_finish) state <= accel_pkg::ADD_WAIT_RETURN;
				accel_pkg::ADD_WAIT_RETURN: if (return_finish) state <= accel_pkg::ADD_DONE;
				default: state <= accel_pkg::ADD_IDLE;
			endcase
		end
	end

	// single pass launches everything together
	always_comb begin
		strobes                = '0;
		strobes.load_feature   = launch_q;
		strobes.compute_begin  = launch_q;
		strobes.return_req     = launch_q;
		strobes.refresh_return = launch_q;
		strobes.free_read_addr = (state == accel_pkg::ADD_DONE);
	end

	assign wait_return = (state == accel_pkg::ADD_WAIT_RETURN);
	assign done        = (state == accel_pkg::ADD_DONE);

endmodule

// File: hw/conv_sequencer.sv
// ######################################
// convolution layer sequencer
// ######################################
`timescale 1ns/1ps

module conv_sequencer (
	input  logic                    system_clk,
	input  logic                    rst_n,
	input  logic                    go,
	input  accel_pkg::patch_cnt_t   in_patches,
	input  accel_pkg::patch_cnt_t   out_patches,
	input  logic                    weights_ready,
	input  logic                    compute_finish,
	input  logic                    return_finish,
	output accel_pkg::ctrl_strobe_t strobes,
	output logic                    wait_return,
	output logic                    done
);

	accel_pkg::conv_state_e state;
	accel_pkg::patch_cnt_t  in_cnt;
	accel_pkg::patch_cnt_t  out_cnt;
	logic                   last_round;
	logic                   in_complete;
	logic                   last_out;

	assign last_round  = (in_cnt == accel_pkg::patch_cnt_t'(in_patches - 8'd1));
	assign in_complete = (in_cnt == in_patches);
	assign last_out    = (out_cnt == accel_pkg::patch_cnt_t'(out_patches - 8'd1));

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= accel_pkg::CONV_IDLE;
			in_cnt  <= '0;
			out_cnt <= '0;
		end else begin
			case (state)
				accel_pkg::CONV_IDLE: if (go) state <= accel_pkg::CONV_CHANGE;
				accel_pkg::CONV_CHANGE: state <= accel_pkg::CONV_WAIT_WEIGHTS;
				accel_pkg::CONV_WAIT_WEIGHTS: begin
					if (weights_ready)
						state <= accel_pkg::CONV_WAIT_COMPUTE;
				end
				accel_pkg::CONV_WAIT_COMPUTE: begin
					if (compute_finish) begin
						in_cnt <= in_cnt + 8'd1;
						state  <= accel_pkg::CONV_CHECK_IN;
					end
				end
				accel_pkg::CONV_CHECK_IN: begin
					state <= in_complete ? accel_pkg::CONV_WAIT_RETURN : accel_pkg::CONV_CHANGE;
				end
				accel_pkg::CONV_WAIT_RETURN: begin
					if (return_finish) begin
						in_cnt  <= '0;
						out_cnt <= out_cnt + 8'd1;
						state   <= accel_pkg::CONV_CHECK_OUT;
					end
				end
				accel_pkg::CONV_CHECK_OUT: begin
					if (out_cnt == out_patches)
						state <= accel_pkg::CONV_DONE;
					else
						state <= accel_pkg::CONV_CHANGE;
				end
				accel_pkg::CONV_DONE: begin
					out_cnt <= '0;
					state   <= accel_pkg::CONV_IDLE;
				end
				default: state <= accel_pkg::CONV_IDLE;
			endcase
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			strobes <= '0;
		end else begin
			strobes.load_feature   <= 1'b0;
			strobes.compute_begin  <= 1'b0;
			strobes.return_req     <= 1'b0;
			strobes.refresh_return <= 1'b0;
			strobes.free_read_addr <= 1'b0;
			strobes.change_weights <= accel_pkg::WCHG_IDLE;
			if (state == accel_pkg::CONV_CHANGE) begin
				// first input patch also reloads bias
				strobes.change_weights <= (in_cnt == '0) ? accel_pkg::WCHG_FULL :
					accel_pkg::WCHG_WEIGHTS;
				strobes.load_feature   <= last_round;
				strobes.return_req     <= last_round;
				strobes.refresh_return <= last_round && (out_cnt == '0);
				strobes.direct_out     <= last_round; // held until next change
			end
			if (state == accel_pkg::CONV_WAIT_WEIGHTS && weights_ready)
				strobes.compute_begin <= 1'b1;
			if (state == accel_pkg::CONV_CHECK_IN && in_complete && last_out)
				strobes.free_read_addr <= 1'b1;
		end
	end

	assign wait_return = (state == accel_pkg::CONV_WAIT_RETURN);
	assign done        = (state == accel_pkg::CONV_DONE);

endmodule

// File: hw/layer_dispatch.sv
// ######################################
// task dispatcher
// ######################################
`timescale 1ns/1ps

module layer_dispatch (
	input  logic                    system_clk,
	input  logic                    rst_n,
	input  logic                    task_start,
	input  logic                    task_finish,
	input  logic                    calculate_start,
	input  accel_pkg::accel_cmd_t   cmd,
	input  logic                    conv_done,
	input  logic                    add_done,
	input  logic                    single_done,
	output logic                    conv_go,
	output logic                    add_go,
	output logic                    single_go,
	output accel_pkg::accel_cmd_t   cmd_latched,
	output accel_pkg::path_sel_t    path_sel,
	output logic                    idle
);

	accel_pkg::task_state_e state;
	logic                   order_valid;

	assign order_valid = cmd.order inside {accel_pkg::OP_CONV, accel_pkg::OP_ADD,
		accel_pkg::OP_POOL, accel_pkg::OP_UPSAMPLE};

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= accel_pkg::TASK_IDLE;
			conv_go   <= 1'b0;
			add_go    <= 1'b0;
			single_go <= 1'b0;
		end else begin
			conv_go   <= 1'b0;
			add_go    <= 1'b0;
			single_go <= 1'b0;
			case (state)
				accel_pkg::TASK_IDLE: begin
					if (task_start)
						state <= accel_pkg::TASK_WAIT_ORDER;
				end
				accel_pkg::TASK_WAIT_ORDER: begin
					if (calculate_start) begin
						case (cmd.order)
							accel_pkg::OP_CONV: begin
								state   <= accel_pkg::TASK_WAIT_CONV;
								conv_go <= 1'b1;
							end
							accel_pkg::OP_ADD: begin
								state  <= accel_pkg::TASK_WAIT_ADD;
								add_go <= 1'b1;
							end
							accel_pkg::OP_POOL, accel_pkg::OP_UPSAMPLE: begin
								state     <= accel_pkg::TASK_WAIT_SINGLE;
								single_go <= 1'b1;
							end
							default: ; // unknown order dropped
						endcase
					end else if (task_finish) begin
						state <= accel_pkg::TASK_IDLE;
					end
				end
				accel_pkg::TASK_WAIT_CONV: if (conv_done) state <= accel_pkg::TASK_WAIT_ORDER;
				accel_pkg::TASK_WAIT_ADD: if (add_done) state <= accel_pkg::TASK_WAIT_ORDER;
				accel_pkg::TASK_WAIT_SINGLE: if (single_done) state <= accel_pkg::TASK_WAIT_ORDER;
				default: state <= accel_pkg::TASK_IDLE;
			endcase
		end
	end

	// command held for the whole layer
	always_ff @(posedge system_clk) begin
		if (state == accel_pkg::TASK_WAIT_ORDER && calculate_start && order_valid)
			cmd_latched <= cmd;
	end

	assign idle = (state == accel_pkg::TASK_IDLE) || (state == accel_pkg::TASK_WAIT_ORDER);

	always_comb begin
		path_sel      = '0;
		path_sel.conv = (state == accel_pkg::TASK_WAIT_CONV);
		path_sel.add  = (state == accel_pkg::TASK_WAIT_ADD);
		path_sel.pool = (state == accel_pkg::TASK_WAIT_SINGLE) &&
			(cmd_latched.order == accel_pkg::OP_POOL);
		path_sel.upsample = (state == accel_pkg::TASK_WAIT_SINGLE) &&
			(cmd_latched.order == accel_pkg::OP_UPSAMPLE);
	end

endmodule

// File: hw/accel_pkg.sv
// ######################################
// accelerator control types
// ######################################
package accel_pkg;

	typedef enum logic [2:0] {
		OP_CONV     = 3'd1,
		OP_ADD      = 3'd2,
		OP_POOL     = 3'd3,
		OP_UPSAMPLE = 3'd4
	} op_e;

	typedef logic [7:0] patch_cnt_t; // legal range 1..255
	typedef logic [1:0] wchange_t;

	localparam wchange_t WCHG_IDLE    = 2'd0;
	localparam wchange_t WCHG_WEIGHTS = 2'd1;
	localparam wchange_t WCHG_FULL    = 2'd3; // weights and bias

	typedef struct packed {
		op_e        order;
		patch_cnt_t in_patches;
		patch_cnt_t out_patches;
	} accel_cmd_t;

	typedef struct packed {
		logic     load_feature;
		logic     compute_begin;
		logic     return_req;
		logic     refresh_return;
		logic     free_read_addr;
		wchange_t change_weights;
		logic     direct_out; // level signal
	} ctrl_strobe_t;

	typedef struct packed {
		logic conv;
		logic add;
		logic pool;
		logic upsample;
	} path_sel_t;

	typedef enum logic [2:0] {
		TASK_IDLE, TASK_WAIT_ORDER, TASK_WAIT_CONV, TASK_WAIT_ADD, TASK_WAIT_SINGLE
	} task_state_e;

	typedef enum logic [2:0] {
		CONV_IDLE, CONV_CHANGE, CONV_WAIT_WEIGHTS, CONV_WAIT_COMPUTE,
		CONV_CHECK_IN, CONV_WAIT_RETURN, CONV_CHECK_OUT, CONV_DONE
	} conv_state_e;

	typedef enum logic [1:0] {
		ADD_IDLE, ADD_WAIT_COMPUTE, ADD_WAIT_RETURN, ADD_DONE
	} add_state_e;

	typedef enum logic [2:0] {
		SINGLE_IDLE, SINGLE_LOAD, SINGLE_WAIT_COMPUTE, SINGLE_WAIT_RETURN,
		SINGLE_CHECK, SINGLE_DONE
	} single_state_e;

endpackage
